// File: source/vertex_job_pkg.sv
`default_nettype none

package vertex_job_pkg;

	//////////////////////////////////////////////////////////////////////
	// vertex sizes
	//////////////////////////////////////////////////////////////////////
	localparam int VERTEX_W             = 32;
	localparam int CACHELINE_VERTEX_NUM = 8;   // one line of 32-bit lanes
	localparam int VERTEX_QUEUE_DEPTH   = 2 * CACHELINE_VERTEX_NUM;

	localparam int BATCH_W     = $clog2(CACHELINE_VERTEX_NUM + 1);
	localparam int QUEUE_PTR_W = $clog2(VERTEX_QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(VERTEX_QUEUE_DEPTH + 1);

	// per-vertex arrays that double as the read tag
	typedef enum logic [1:0] {
		IN_DEGREE  = 2'd0,
		OUT_DEGREE = 2'd1,
		EDGES_IDX  = 2'd2
	} vertex_array_e;

	typedef struct packed {
		logic [VERTEX_W-1:0] id;
		logic [VERTEX_W-1:0] in_degree;
		logic [VERTEX_W-1:0] out_degree;
		logic [VERTEX_W-1:0] edges_idx;
	} vertex_rec_t;

endpackage

`default_nettype wire

// File: source/mem_read_pkg.sv
`default_nettype none

package mem_read_pkg;

	localparam int ADDR_W          = 64;   // byte address
	localparam int CACHELINE_W     = 256;
	localparam int CACHELINE_BYTES = CACHELINE_W / 8;

	// read command credits after reset
	localparam int READ_CREDITS = 2;
	localparam int CREDIT_W     = $clog2(READ_CREDITS + 1);

	// at most three reads of one batch in flight
	localparam int RESP_CNT_W = 2;

endpackage

`default_nettype wire

// File: source/job_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface job_cfg_if import vertex_job_pkg::*, mem_read_pkg::*; ();

	logic                start;        // one-cycle job start
	logic [VERTEX_W-1:0] num_vertices;
	logic [ADDR_W-1:0]   in_degree_base;
	logic [ADDR_W-1:0]   out_degree_base;
	logic [ADDR_W-1:0]   edges_idx_base;

	modport cfg (
		output start, num_vertices, in_degree_base, out_degree_base, edges_idx_base
	);

	modport user (
		input start, num_vertices, in_degree_base, out_degree_base, edges_idx_base
	);

endinterface

`default_nettype wire

// File: source/vertex_job_config.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_job_config import vertex_job_pkg::*, mem_read_pkg::*; (
	input  logic                clock,
	input  logic                rstn,
	input  logic                wed_valid,
	input  logic [VERTEX_W-1:0] wed_num_vertices,
	input  logic [ADDR_W-1:0]   wed_in_degree_base,
	input  logic [ADDR_W-1:0]   wed_out_degree_base,
	input  logic [ADDR_W-1:0]   wed_edges_idx_base,
	input  logic                vertex_pushed,
	input  logic                vertex_filtered,
	job_cfg_if.cfg              cfg,
	output logic [VERTEX_W-1:0] vertices_pushed,
	output logic [VERTEX_W-1:0] vertices_filtered
);

	//////////////////////////////////////////////////////////////////////
	// job descriptor
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (wed_valid) begin
			cfg.num_vertices    <= wed_num_vertices;
			cfg.in_degree_base  <= wed_in_degree_base;
			cfg.out_degree_base <= wed_out_degree_base;
			cfg.edges_idx_base  <= wed_edges_idx_base;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cfg.start <= 1'b0;
		end else begin
			cfg.start <= wed_valid;   // descriptor is stable by now
		end
	end

	//////////////////////////////////////////////////////////////////////
	// status counters
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertices_pushed   <= '0;
			vertices_filtered <= '0;
		end else if (cfg.start) begin
			vertices_pushed   <= '0;
			vertices_filtered <= '0;
		end else begin
			if (vertex_pushed)
				vertices_pushed <= vertices_pushed + 1'b1;
			if (vertex_filtered)
				vertices_filtered <= vertices_filtered + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/vertex_read_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_read_issuer import vertex_job_pkg::*, mem_read_pkg::*; (
	input  logic               clock,
	input  logic               rstn,
	input  logic               rd_credit,
	input  logic               rd_data_valid,
	input  logic [2:0]         unpack_busy,
	input  logic               queue_has_room,
	job_cfg_if.user            cfg,
	output logic               rd_cmd_valid,
	output logic [ADDR_W-1:0]  rd_cmd_addr,
	output vertex_array_e      rd_cmd_tag,
	output logic [BATCH_W-1:0] batch_len
);

	typedef enum logic [2:0] {
		IDLE,
		WAIT_BATCH,
		SEND_IN_DEGREE,
		SEND_OUT_DEGREE,
		SEND_EDGES_IDX
	} issue_state_e;

	issue_state_e state, next_state;

	logic [VERTEX_W-1:0]   remaining;
	logic [ADDR_W-1:0]     line_offset;
	logic [CREDIT_W-1:0]   credits;
	logic [RESP_CNT_W-1:0] outstanding;
	logic [ADDR_W-1:0]     cmd_base;
	logic [BATCH_W-1:0]    batch_next;
	logic                  batch_ready;
	logic                  job_load;
	logic                  batch_start;
	logic                  sending;

	assign batch_next = (remaining >= VERTEX_W'(CACHELINE_VERTEX_NUM)) ?
		BATCH_W'(CACHELINE_VERTEX_NUM) : remaining[BATCH_W-1:0];

	// previous batch fully drained and queue can take a whole line
	assign batch_ready = (remaining != '0) && (outstanding == '0) &&
		(unpack_busy == 3'b000) && queue_has_room;

	assign job_load    = (state == IDLE) && cfg.start;
	assign batch_start = (state == WAIT_BATCH) && batch_ready;
	assign sending     = (state == SEND_IN_DEGREE) || (state == SEND_OUT_DEGREE) ||
		(state == SEND_EDGES_IDX);

	//////////////////////////////////////////////////////////////////////
	// batch FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (cfg.start)
					next_state = WAIT_BATCH;
			end
			WAIT_BATCH: begin
				if (remaining == '0)
					next_state = IDLE;   // job fully requested
				else if (batch_ready)
					next_state = SEND_IN_DEGREE;
			end
			SEND_IN_DEGREE: begin
				if (rd_cmd_valid)
					next_state = SEND_OUT_DEGREE;
			end
			SEND_OUT_DEGREE: begin
				if (rd_cmd_valid)
					next_state = SEND_EDGES_IDX;
			end
			SEND_EDGES_IDX: begin
				if (rd_cmd_valid)
					next_state = WAIT_BATCH;
			end
			default: next_state = IDLE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// command channel
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (state)
			SEND_OUT_DEGREE: begin
				rd_cmd_tag = OUT_DEGREE;
				cmd_base   = cfg.out_degree_base;
			end
			SEND_EDGES_IDX: begin
				rd_cmd_tag = EDGES_IDX;
				cmd_base   = cfg.edges_idx_base;
			end
			default: begin
				rd_cmd_tag = IN_DEGREE;
				cmd_base   = cfg.in_degree_base;
			end
		endcase
	end

	assign rd_cmd_valid = sending && (credits != '0);
	assign rd_cmd_addr  = cmd_base + line_offset;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining   <= '0;
			line_offset <= '0;
			batch_len   <= '0;
		end else if (job_load) begin
			remaining   <= cfg.num_vertices;
			line_offset <= '0;
		end else if (batch_start) begin
			batch_len <= batch_next;   // held for the unpackers until next batch
			remaining <= remaining - VERTEX_W'(batch_next);
		end else if (rd_cmd_valid && state == SEND_EDGES_IDX) begin
			line_offset <= line_offset + ADDR_W'(CACHELINE_BYTES);
		end
	end

	// credits and responses still owed
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits     <= CREDIT_W'(READ_CREDITS);
			outstanding <= '0;
		end else begin
			credits     <= credits - CREDIT_W'(rd_cmd_valid) + CREDIT_W'(rd_credit);
			outstanding <= outstanding + RESP_CNT_W'(rd_cmd_valid) -
				RESP_CNT_W'(rd_data_valid);
		end
	end

endmodule

`default_nettype wire

// File: source/cacheline_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module cacheline_unpacker import vertex_job_pkg::*, mem_read_pkg::*; #(
	parameter vertex_array_e ARRAY = IN_DEGREE
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   rd_data_valid,
	input  vertex_array_e          rd_data_tag,
	input  logic [CACHELINE_W-1:0] rd_data,
	input  logic [BATCH_W-1:0]     batch_len,
	input  logic                   advance,
	output logic [VERTEX_W-1:0]    value,
	output logic                   valid,
	output logic                   busy
);

	logic [CACHELINE_W-1:0] line;
	logic [BATCH_W-1:0]     left;    // values not yet consumed
	logic                   capture;

	assign capture = rd_data_valid && (rd_data_tag == ARRAY);

	// lane 0 always sits at the bottom
	always_ff @(posedge clock) begin
		if (capture)
			line <= rd_data;
		else if (advance)
			line <= line >> VERTEX_W;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			left <= '0;
		end else if (capture) begin
			left <= batch_len;
		end else if (advance && left != '0) begin
			left <= left - 1'b1;
		end
	end

	assign value = line[VERTEX_W-1:0];
	assign valid = (left != '0);
	assign busy  = valid || capture;   // covers the capture cycle too

endmodule

`default_nettype wire

// File: source/vertex_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_assembler import vertex_job_pkg::*; (
	input  logic                clock,
	input  logic                rstn,
	input  logic [VERTEX_W-1:0] in_degree,
	input  logic [VERTEX_W-1:0] out_degree,
	input  logic [VERTEX_W-1:0] edges_idx,
	input  logic                in_valid,
	input  logic                out_valid,
	input  logic                edges_valid,
	job_cfg_if.user             cfg,
	output logic                advance,
	output vertex_rec_t         rec,
	output logic                push,
	output logic                vertex_pushed,
	output logic                vertex_filtered
);

	logic [VERTEX_W-1:0] next_id;
	logic                rec_valid;
	logic                has_edges;

	assign advance = in_valid && out_valid && edges_valid;

	always_ff @(posedge clock) begin
		if (advance)
			rec <= '{id: next_id, in_degree: in_degree, out_degree: out_degree,
				edges_idx: edges_idx};
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			next_id   <= '0;
			rec_valid <= 1'b0;
		end else begin
			rec_valid <= advance;
			if (cfg.start)
				next_id <= '0;   // ids restart per job
			else if (advance)
				next_id <= next_id + 1'b1;
		end
	end

	// isolated vertices are counted but never queued
	assign has_edges       = (rec.in_degree != '0) || (rec.out_degree != '0);
	assign push            = rec_valid && has_edges;
	assign vertex_pushed   = push;
	assign vertex_filtered = rec_valid && !has_edges;

endmodule

`default_nettype wire

// File: source/vertex_job_queue.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_job_queue import vertex_job_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        push,
	input  vertex_rec_t rec,
	input  logic        vertex_request,
	output logic        vertex_valid,
	output vertex_rec_t head,
	output logic        has_room
);

	vertex_rec_t            mem [VERTEX_QUEUE_DEPTH];
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_CNT_W-1:0] count;
	logic                   pop;

	assign pop = vertex_request && vertex_valid;   // request on empty is dropped

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= rec;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + QUEUE_CNT_W'(push) - QUEUE_CNT_W'(pop);
		end
	end

	// show-ahead head
	assign vertex_valid = (count != '0);
	assign head         = mem[rd_ptr];

	// a record sitting in the assembler is already committed
	assign has_room = (count + QUEUE_CNT_W'(push)) <=
		QUEUE_CNT_W'(VERTEX_QUEUE_DEPTH - CACHELINE_VERTEX_NUM);

endmodule

`default_nettype wire

// File: source/vertex_job_top.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_job_top import vertex_job_pkg::*, mem_read_pkg::*; (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   wed_valid,
	input  logic [VERTEX_W-1:0]    wed_num_vertices,
	input  logic [ADDR_W-1:0]      wed_in_degree_base,
	input  logic [ADDR_W-1:0]      wed_out_degree_base,
	input  logic [ADDR_W-1:0]      wed_edges_idx_base,
	output logic                   rd_cmd_valid,
	output logic [ADDR_W-1:0]      rd_cmd_addr,
	output vertex_array_e          rd_cmd_tag,
	input  logic                   rd_credit,
	input  logic                   rd_data_valid,
	input  vertex_array_e          rd_data_tag,
	input  logic [CACHELINE_W-1:0] rd_data,
	output logic                   vertex_valid,
	output logic [VERTEX_W-1:0]    vertex_id,
	output logic [VERTEX_W-1:0]    vertex_in_degree,
	output logic [VERTEX_W-1:0]    vertex_out_degree,
	output logic [VERTEX_W-1:0]    vertex_edges_idx,
	input  logic                   vertex_request,
	output logic [VERTEX_W-1:0]    vertices_pushed,
	output logic [VERTEX_W-1:0]    vertices_filtered
);

	job_cfg_if cfg_bus ();

	logic [BATCH_W-1:0]  batch_len;
	logic [2:0]          unpack_busy;
	logic [VERTEX_W-1:0] in_degree, out_degree, edges_idx;
	logic                in_valid, out_valid, edges_valid;
	logic                advance, push, vertex_pushed, vertex_filtered;
	logic                queue_has_room;
	vertex_rec_t         rec, head;

	vertex_job_config u_config (
		.clock, .rstn, .wed_valid, .wed_num_vertices, .wed_in_degree_base,
		.wed_out_degree_base, .wed_edges_idx_base, .vertex_pushed, .vertex_filtered,
		.cfg (cfg_bus.cfg), .vertices_pushed, .vertices_filtered
	);

	vertex_read_issuer u_issuer (
		.clock, .rstn, .rd_credit, .rd_data_valid, .unpack_busy, .queue_has_room,
		.cfg (cfg_bus.user), .rd_cmd_valid, .rd_cmd_addr, .rd_cmd_tag, .batch_len
	);

	//////////////////////////////////////////////////////////////////////
	// one unpacker per array
	//////////////////////////////////////////////////////////////////////
	cacheline_unpacker #(.ARRAY(IN_DEGREE)) u_unpack_in (
		.clock, .rstn, .rd_data_valid, .rd_data_tag, .rd_data, .batch_len, .advance,
		.value (in_degree), .valid (in_valid), .busy (unpack_busy[0])
	);

	cacheline_unpacker #(.ARRAY(OUT_DEGREE)) u_unpack_out (
		.clock, .rstn, .rd_data_valid, .rd_data_tag, .rd_data, .batch_len, .advance,
		.value (out_degree), .valid (out_valid), .busy (unpack_busy[1])
	);

	cacheline_unpacker #(.ARRAY(EDGES_IDX)) u_unpack_edges (
		.clock, .rstn, .rd_data_valid, .rd_data_tag, .rd_data, .batch_len, .advance,
		.value (edges_idx), .valid (edges_valid), .busy (unpack_busy[2])
	);

	vertex_assembler u_assembler (
		.clock, .rstn, .in_degree, .out_degree, .edges_idx, .in_valid, .out_valid,
		.edges_valid, .cfg (cfg_bus.user), .advance, .rec, .push, .vertex_pushed,
		.vertex_filtered
	);

	vertex_job_queue u_queue (
		.clock, .rstn, .push, .rec, .vertex_request, .vertex_valid, .head,
		.has_room (queue_has_room)
	);

	assign vertex_id         = head.id;
	assign vertex_in_degree  = head.in_degree;
	assign vertex_out_degree = head.out_degree;
	assign vertex_edges_idx  = head.edges_idx;

endmodule

`default_nettype wire

// File: test/vertex_job_properties.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_job_properties import vertex_job_pkg::*, mem_read_pkg::*; (
	input logic clock,
	input logic rstn,
	input logic rd_cmd_valid,
	input logic rd_credit,
	input logic push,
	input logic vertex_valid,
	input logic vertex_request
);

	logic [2:0] in_flight;   // commands whose credit is still out
	logic [5:0] occupancy;   // queue entries seen from the outside
	logic       pop;

	assign pop = vertex_valid && vertex_request;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_flight <= '0;
			occupancy <= '0;
		end else begin
			in_flight <= in_flight + 3'(rd_cmd_valid) - 3'(rd_credit);
			occupancy <= occupancy + 6'(push) - 6'(pop);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read credits
	//////////////////////////////////////////////////////////////////////
	credit_limit: assert property (@(posedge clock) disable iff (!rstn)
		in_flight <= 3'(READ_CREDITS))
		else $error("more read commands in flight than credits granted");

	cmd_needs_credit: assert property (@(posedge clock) disable iff (!rstn)
		rd_cmd_valid |-> in_flight < 3'(READ_CREDITS))
		else $error("read command sent without a credit");

	//////////////////////////////////////////////////////////////////////
	// vertex queue
	//////////////////////////////////////////////////////////////////////
	queue_no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		occupancy <= 6'(VERTEX_QUEUE_DEPTH))
		else $error("vertex queue overflow");

	valid_held: assert property (@(posedge clock) disable iff (!rstn)
		vertex_valid && !vertex_request |=> vertex_valid)
		else $error("vertex_valid dropped without a pop");

endmodule

bind vertex_job_top vertex_job_properties u_properties (
	.clock, .rstn, .rd_cmd_valid, .rd_credit, .push, .vertex_valid, .vertex_request
);

`default_nettype wire

// File: test/tb_vertex_job.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vertex_job import vertex_job_pkg::*, mem_read_pkg::*; ();

	logic                   clock;
	logic                   rstn;
	logic                   wed_valid;
	logic [VERTEX_W-1:0]    wed_num_vertices;
	logic [ADDR_W-1:0]      wed_in_degree_base;
	logic [ADDR_W-1:0]      wed_out_degree_base;
	logic [ADDR_W-1:0]      wed_edges_idx_base;
	logic                   rd_cmd_valid;
	logic [ADDR_W-1:0]      rd_cmd_addr;
	vertex_array_e          rd_cmd_tag;
	logic                   rd_credit;
	logic                   rd_data_valid;
	vertex_array_e          rd_data_tag;
	logic [CACHELINE_W-1:0] rd_data;
	logic                   vertex_valid;
	logic [VERTEX_W-1:0]    vertex_id;
	logic [VERTEX_W-1:0]    vertex_in_degree;
	logic [VERTEX_W-1:0]    vertex_out_degree;
	logic [VERTEX_W-1:0]    vertex_edges_idx;
	logic                   vertex_request;
	logic [VERTEX_W-1:0]    vertices_pushed;
	logic [VERTEX_W-1:0]    vertices_filtered;

	string             test_name;
	bit                run_passed;
	bit                fail_reported;
	int                cycle;
	int                cmd_count;   // commands of the current job
	int                popped;
	int                exp_id;
	logic [ADDR_W-1:0] pend_addr [$];
	vertex_array_e     pend_tag [$];
	int                pend_due [$];
	int                credit_due [$];

	vertex_job_top u_dut (.*);

	initial begin : clock_gen
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [ADDR_W-1:0] array_base(vertex_array_e arr);
		case (arr)
			IN_DEGREE:  return 64'h0000_0000_1000_0000;
			OUT_DEGREE: return 64'h0000_0000_2000_0000;
			default:    return 64'h0000_0000_3000_0000;
		endcase
	endfunction

	// test graph contents per vertex index
	function automatic logic [VERTEX_W-1:0] array_value(vertex_array_e arr, int idx);
		case (arr)
			IN_DEGREE:  return VERTEX_W'(idx % 3);
			OUT_DEGREE: return VERTEX_W'(idx % 2);
			default:    return VERTEX_W'(4 * idx);
		endcase
	endfunction

	function automatic logic [CACHELINE_W-1:0] make_line(vertex_array_e arr,
		logic [ADDR_W-1:0] addr);
		logic [CACHELINE_W-1:0] line;
		int                     first;
		first = int'((addr - array_base(arr)) / 4);
		for (int j = 0; j < CACHELINE_VERTEX_NUM; j++)
			line[j*VERTEX_W +: VERTEX_W] = array_value(arr, first + j);
		return line;
	endfunction

	function automatic vertex_array_e tag_for_step(int step);
		case (step % 3)
			0:       return IN_DEGREE;
			1:       return OUT_DEGREE;
			default: return EDGES_IDX;
		endcase
	endfunction

	// both degrees are zero exactly on multiples of 6
	function automatic int next_kept_id(int id);
		int next;
		next = id + 1;
		if (next % 6 == 0)
			next = next + 1;
		return next;
	endfunction

	task automatic stop_run(string reason);
		fail_reported = 1'b1;
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
		stop_run($sformatf("[ERROR] %s %s: expected %0d, actual %0d", test_name, what,
			expected, actual));
	endtask

	//////////////////////////////////////////////////////////////////////
	// memory model and consumer
	//////////////////////////////////////////////////////////////////////
	task automatic record_command();
		vertex_array_e     tag;
		logic [ADDR_W-1:0] addr;
		tag  = tag_for_step(cmd_count);
		addr = array_base(tag) + ADDR_W'((cmd_count / 3) * CACHELINE_BYTES);
		assert (rd_cmd_tag == tag)
			else report_mismatch("read tag", 64'(tag), 64'(rd_cmd_tag));
		assert (rd_cmd_addr == addr)
			else report_mismatch("read address", addr, rd_cmd_addr);
		pend_addr.push_back(rd_cmd_addr);
		pend_tag.push_back(rd_cmd_tag);
		pend_due.push_back(cycle + 1 + int'($urandom % 6));
		credit_due.push_back(cycle + 1 + int'($urandom % 12));   // long waits hold credit back
		cmd_count++;
	endtask

	task automatic check_pop();
		assert (vertex_id < wed_num_vertices)
			else stop_run($sformatf("%s: vertex id %0d lies outside the job", test_name,
				vertex_id));
		assert (vertex_id == VERTEX_W'(exp_id))
			else report_mismatch("vertex id", 64'(exp_id), 64'(vertex_id));
		assert (vertex_in_degree == array_value(IN_DEGREE, exp_id))
			else report_mismatch("in_degree", 64'(array_value(IN_DEGREE, exp_id)),
				64'(vertex_in_degree));
		assert (vertex_out_degree == array_value(OUT_DEGREE, exp_id))
			else report_mismatch("out_degree", 64'(array_value(OUT_DEGREE, exp_id)),
				64'(vertex_out_degree));
		assert (vertex_edges_idx == array_value(EDGES_IDX, exp_id))
			else report_mismatch("edges_idx", 64'(array_value(EDGES_IDX, exp_id)),
				64'(vertex_edges_idx));
		popped++;
		exp_id = next_kept_id(exp_id);
	endtask

	initial begin : bus_model
		int hit;
		void'($urandom(32'hee1b_a7b9));
		rd_credit      = 1'b0;
		rd_data_valid  = 1'b0;
		rd_data_tag    = IN_DEGREE;
		rd_data        = '0;
		vertex_request = 1'b0;
		cycle          = 0;
		cmd_count      = 0;
		popped         = 0;
		exp_id         = next_kept_id(-1);
		forever begin
			@(posedge clock);   // sample
			cycle++;
			if (rstn && wed_valid) begin
				cmd_count = 0;
				popped    = 0;
				exp_id    = next_kept_id(-1);
			end
			if (rstn && rd_cmd_valid)
				record_command();
			if (rstn && vertex_valid && vertex_request)
				check_pop();
			@(negedge clock);   // drive
			rd_data_valid = 1'b0;
			rd_credit     = 1'b0;
			if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
				rd_data_valid = 1'b1;
				rd_data_tag   = pend_tag[0];
				rd_data       = make_line(pend_tag[0], pend_addr[0]);
				pend_due.delete(0);
				pend_tag.delete(0);
				pend_addr.delete(0);
			end
			hit = -1;
			foreach (credit_due[k])
				if (hit < 0 && credit_due[k] <= cycle)
					hit = k;
			if (hit >= 0) begin
				rd_credit = 1'b1;
				credit_due.delete(hit);
			end
			vertex_request = (($urandom % 3) == 0);   // slow consumer fills the queue
		end
	end

	//////////////////////////////////////////////////////////////////////
	// jobs
	//////////////////////////////////////////////////////////////////////
	task automatic run_job(string name, int n);
		int filt;
		int waited;
		test_name = name;
		filt      = 0;
		for (int i = 0; i < n; i++)
			if (i % 6 == 0)
				filt++;
		wed_num_vertices = VERTEX_W'(n);
		wed_valid        = 1'b1;
		@(negedge clock);
		wed_valid = 1'b0;
		@(negedge clock);
		assert (vertices_pushed == '0)
			else report_mismatch("pushed after start", 64'd0, 64'(vertices_pushed));
		assert (vertices_filtered == '0)
			else report_mismatch("filtered after start", 64'd0, 64'(vertices_filtered));

		for (waited = 0; waited < 4000; waited++) begin
			if (vertices_pushed + vertices_filtered == VERTEX_W'(n))
				break;
			@(negedge clock);
		end
		if (waited == 4000)
			stop_run($sformatf("%s: timeout waiting for all vertices to be counted", name));

		for (waited = 0; waited < 4000; waited++) begin
			if (popped == n - filt)
				break;
			@(negedge clock);
		end
		if (waited == 4000)
			stop_run($sformatf("%s: timeout waiting for the consumer to drain", name));

		assert (vertices_filtered == VERTEX_W'(filt))
			else report_mismatch("filtered count", 64'(filt), 64'(vertices_filtered));
		assert (vertices_pushed == VERTEX_W'(n - filt))
			else report_mismatch("pushed count", 64'(n - filt), 64'(vertices_pushed));
		assert (cmd_count == 3 * ((n + CACHELINE_VERTEX_NUM - 1) / CACHELINE_VERTEX_NUM))
			else report_mismatch("read commands", 64'(3 * ((n + 7) / 8)), 64'(cmd_count));
		assert (vertex_valid == 1'b0)
			else report_mismatch("vertex_valid after drain", 64'd0, 64'(vertex_valid));
	endtask

	initial begin : stimulus
		run_passed          = 1'b0;
		fail_reported       = 1'b0;
		test_name           = "reset";
		rstn                = 1'b0;
		wed_valid           = 1'b0;
		wed_num_vertices    = '0;
		wed_in_degree_base  = array_base(IN_DEGREE);
		wed_out_degree_base = array_base(OUT_DEGREE);
		wed_edges_idx_base  = array_base(EDGES_IDX);
		repeat (2) @(negedge clock);
		assert (rd_cmd_valid == 1'b0)
			else report_mismatch("rd_cmd_valid", 64'd0, 64'(rd_cmd_valid));
		assert (vertex_valid == 1'b0)
			else report_mismatch("vertex_valid", 64'd0, 64'(vertex_valid));
		assert (vertices_pushed == '0)
			else report_mismatch("pushed count", 64'd0, 64'(vertices_pushed));
		assert (vertices_filtered == '0)
			else report_mismatch("filtered count", 64'd0, 64'(vertices_filtered));
		rstn = 1'b1;
		@(negedge clock);

		run_job("job_21", 21);   // short last batch
		run_job("job_13", 13);

		run_passed = 1'b1;
		$display("Simulation PASSED");
		$finish;
	end

	final begin
		if (!run_passed && !fail_reported)
			$display("Simulation FAILED");
	end

endmodule

`default_nettype wire

// File: verilog.f
source/vertex_job_pkg.sv
source/mem_read_pkg.sv
source/job_cfg_if.sv
source/vertex_job_config.sv
source/vertex_read_issuer.sv
source/cacheline_unpacker.sv
source/vertex_assembler.sv
source/vertex_job_queue.sv
source/vertex_job_top.sv
test/vertex_job_properties.sv
test/tb_vertex_job.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_vertex_job
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST))
SIM     = $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG) || ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
